/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/10ps --top-module tb_ppu_regs -f sim.f -o tb_ppu_regs \
  && ./obj_dir/tb_ppu_regs | tee /dev/stderr | grep -qF "PASS: all tests" \
  && echo "simulation passed" \
  && exit 0 \
  || { echo "simulation failed"; exit 1; }

/* sim.f */
src/ppu_pkg.sv
src/ppu_regdec.sv
src/video_address.sv
src/vram_buffer.sv
src/ppu_regs_top.sv
verification/tb_clock.sv
verification/tb_ppu_regs.sv

/* src/ppu_pkg.sv */
package ppu_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // register map as seen by the CPU
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [2:0] {
    R_ppu_ctrl = 3'd0,  // control, bit 2 picks the data port step
    R_ppu_mask = 3'd1,
    R_ppu_stat = 3'd2,  // status, reading it clears the write toggle
    R_oam_addr = 3'd3,
    R_oam_data = 3'd4,
    R_ppu_scrl = 3'd5,
    R_ppu_addr = 3'd6,
    R_ppu_data = 3'd7
  } reg_index_e;

  typedef logic [7:0] byte_t;

  // one bit per register, indexed by reg_index_e
  typedef logic [7:0] reg_strobe_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // address widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // layout of v and t, low to high:
  //   4:0   coarse X
  //   9:5   coarse Y
  //   11:10 nametable select
  //   14:12 fine Y
  typedef logic [14:0] loopy_addr_t;

  typedef logic [13:0] vram_addr_t;  // low 14 bits of v
  typedef logic [2:0]  fine_x_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bundles between the blocks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // decoder to address block, strobes are high for a single cycle
  typedef struct packed {
    reg_strobe_t wstrobe;
    reg_strobe_t rstrobe;
    byte_t       wdata;
    logic        incr32;   // copy of control bit 2
  } reg_access_t;

  // address block to video memory
  typedef struct packed {
    vram_addr_t addr;
    byte_t      wdata;
    logic       wren;
  } vram_req_t;

  // request side of the Wishbone classic port
  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    reg_index_e adr;
    byte_t      dat;
  } wb_req_t;

endpackage

/* src/ppu_regdec.sv */
`timescale 1ns/10ps

module ppu_regdec
(
  input  logic                 I_clock,
  input  logic                 I_reset,
  input  ppu_pkg::wb_req_t     wb_req,
  output logic                 ack,
  output ppu_pkg::byte_t       rdata,
  input  ppu_pkg::byte_t       read_buffer,
  output ppu_pkg::reg_access_t access,
  output ppu_pkg::byte_t       render_mask
);

  import ppu_pkg::*;

  logic        bus_start;   // first cycle of a bus access
  reg_strobe_t strobe_sel;
  byte_t       read_sel;
  byte_t       ctrl_q;
  byte_t       mask_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Wishbone slave
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // ack is still low in the first cycle, so each access is seen exactly once
  assign bus_start = wb_req.cyc & wb_req.stb & ~ack;

  always_ff @(posedge I_clock or negedge I_reset)
  begin
    if (!I_reset)
    begin
      ack <= 1'b0;
    end
    else
    begin
      ack <= bus_start;   // one cycle pulse, the master drops stb after it
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one-hot strobes towards the address block
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign strobe_sel = reg_strobe_t'(1) << wb_req.adr;

  always_comb
  begin
    access.wstrobe = (bus_start & wb_req.we) ? strobe_sel : '0;
    access.rstrobe = (bus_start & ~wb_req.we) ? strobe_sel : '0;
    access.wdata   = wb_req.dat;
    access.incr32  = ctrl_q[2];
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control and mask bytes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge I_clock or negedge I_reset)
  begin
    if (!I_reset)
    begin
      ctrl_q <= '0;
      mask_q <= '0;
    end
    else
    begin
      if (access.wstrobe[R_ppu_ctrl])
        ctrl_q <= wb_req.dat;
      if (access.wstrobe[R_ppu_mask])
        mask_q <= wb_req.dat;
    end
  end

  assign render_mask = mask_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read data, presented together with ack
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb
  begin
    case (wb_req.adr)
      R_ppu_data: read_sel = read_buffer;  // value fetched by the previous access
      default:    read_sel = '0;           // no rendering, so status and the rest read zero
    endcase
  end

  always_ff @(posedge I_clock or negedge I_reset)
  begin
    if (!I_reset)
    begin
      rdata <= '0;
    end
    else if (bus_start)
    begin
      rdata <= wb_req.we ? byte_t'(0) : read_sel;
    end
  end

endmodule

/* src/ppu_regs_top.sv */
`timescale 1ns/10ps

module ppu_regs_top
(
  input  logic                 I_clock,
  input  logic                 I_reset,
  input  ppu_pkg::wb_req_t     wb_req,
  output logic                 ack,
  output ppu_pkg::byte_t       rdata,
  output ppu_pkg::vram_addr_t  vram_addr,
  output ppu_pkg::fine_x_t     fine_x,
  output ppu_pkg::byte_t       render_mask
);

  import ppu_pkg::*;

  reg_access_t access;
  byte_t       read_buffer;
  vram_req_t   vram_req;
  byte_t       vram_rdata;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus decoder, address registers, video memory
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  ppu_regdec u_regdec
  (
    .I_clock     (I_clock),
    .I_reset     (I_reset),
    .wb_req      (wb_req),
    .ack         (ack),
    .rdata       (rdata),
    .read_buffer (read_buffer),
    .access      (access),
    .render_mask (render_mask)
  );

  video_address u_video_address
  (
    .I_clock     (I_clock),
    .I_reset     (I_reset),
    .access      (access),
    .vram_rdata  (vram_rdata),
    .vram_req    (vram_req),
    .fine_x      (fine_x),
    .read_buffer (read_buffer)
  );

  vram_buffer u_vram_buffer
  (
    .I_clock (I_clock),
    .req     (vram_req),
    .rdata   (vram_rdata)
  );

  assign vram_addr = vram_req.addr;  // current v as seen by the renderer

endmodule

/* src/video_address.sv */
`timescale 1ns/10ps

module video_address
(
  input  logic                 I_clock,
  input  logic                 I_reset,
  input  ppu_pkg::reg_access_t access,
  input  ppu_pkg::byte_t       vram_rdata,
  output ppu_pkg::vram_req_t   vram_req,
  output ppu_pkg::fine_x_t     fine_x,
  output ppu_pkg::byte_t       read_buffer
);

  import ppu_pkg::*;

  loopy_addr_t v_addr;       // current video address
  loopy_addr_t t_addr;       // temporary address, built up by scroll and address writes
  loopy_addr_t v_step;
  fine_x_t     fine_q;
  logic        toggle;       // low selects the first write of a pair
  byte_t       rbuf_q;
  logic        data_access;

  assign data_access = access.wstrobe[R_ppu_data] | access.rstrobe[R_ppu_data];
  assign v_step      = access.incr32 ? loopy_addr_t'(32) : loopy_addr_t'(1);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // shared first/second write toggle
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge I_clock or negedge I_reset)
  begin
    if (!I_reset)
      toggle <= 1'b0;
    else if (access.rstrobe[R_ppu_stat])
      toggle <= 1'b0;
    else if (access.wstrobe[R_ppu_addr] | access.wstrobe[R_ppu_scrl])
      toggle <= ~toggle;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // t and fine X
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge I_clock or negedge I_reset)
  begin
    if (!I_reset)
    begin
      t_addr <= '0;
      fine_q <= '0;
    end
    else if (access.wstrobe[R_ppu_ctrl])
    begin
      t_addr[11:10] <= access.wdata[1:0];  // nametable select
    end
    else if (access.wstrobe[R_ppu_scrl])
    begin
      if (!toggle)
      begin
        t_addr[4:0] <= access.wdata[7:3];
        fine_q      <= access.wdata[2:0];
      end
      else
      begin
        t_addr[9:5]   <= access.wdata[7:3];
        t_addr[14:12] <= access.wdata[2:0];
      end
    end
    else if (access.wstrobe[R_ppu_addr])
    begin
      if (!toggle)
      begin
        t_addr[14]   <= 1'b0;              // top bit is out of reach of the CPU
        t_addr[13:8] <= access.wdata[5:0];
      end
      else
      begin
        t_addr[7:0] <= access.wdata;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // v, loaded from t and stepped by the data port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge I_clock or negedge I_reset)
  begin
    if (!I_reset)
      v_addr <= '0;
    else if (data_access)
      v_addr <= v_addr + v_step;
    else if (access.wstrobe[R_ppu_addr] && toggle)
      v_addr <= {t_addr[14:8], access.wdata};  // t with its new low byte
  end

  // the memory output already holds the byte at v when a data read strobes
  always_ff @(posedge I_clock or negedge I_reset)
  begin
    if (!I_reset)
      rbuf_q <= '0;
    else if (access.rstrobe[R_ppu_data])
      rbuf_q <= vram_rdata;
  end

  // write goes to the old v while v steps on the same edge
  always_comb
  begin
    vram_req.addr  = v_addr[13:0];
    vram_req.wdata = access.wdata;
    vram_req.wren  = access.wstrobe[R_ppu_data];
  end

  assign fine_x      = fine_q;
  assign read_buffer = rbuf_q;

endmodule

/* src/vram_buffer.sv */
`timescale 1ns/10ps

module vram_buffer
(
  input  logic                 I_clock,
  input  ppu_pkg::vram_req_t   req,
  output ppu_pkg::byte_t       rdata
);

  import ppu_pkg::*;

  localparam int VRAM_DEPTH = 1 << $bits(vram_addr_t);  // 16 KiB

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // single-port array, contents come up undefined
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  byte_t mem [VRAM_DEPTH];

  always_ff @(posedge I_clock)
  begin
    if (req.wren)
    begin
      mem[req.addr] <= req.wdata;
    end
  end

  // read every cycle, a write in the same cycle returns the old byte
  always_ff @(posedge I_clock)
  begin
    rdata <= mem[req.addr];
  end

endmodule

/* verification/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock
#(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 10
)
(
  output logic I_clock,
  output logic I_reset
);

  initial
  begin
    I_clock = 1'b0;
    forever #(PERIOD_NS / 2) I_clock = ~I_clock;
  end

  initial
  begin
    I_reset = 1'b0;
    repeat (RESET_CYCLES) @(posedge I_clock);
    @(negedge I_clock);
    I_reset = 1'b1;   // released away from the active edge
  end

endmodule

/* verification/tb_ppu_regs.sv */
`timescale 1ns/10ps

module tb_ppu_regs;

  import ppu_pkg::*;

  localparam int          CLK_PERIOD_NS     = 20;
  localparam int          RESET_CYCLES      = 10;
  localparam int          ACK_LIMIT         = 4;
  localparam int          CYCLES_PER_ACCESS = 6;
  localparam int          FILL_BYTES        = 16;
  localparam int          FILL_LEN          = 2 * FILL_BYTES + 5;  // writes, reads, stale read, two address pairs
  localparam vram_addr_t  FILL_BASE         = 14'h2100;
  localparam logic [31:0] LCG_SEED          = 32'h0158880c;
  localparam logic        WR                = 1'b1;
  localparam logic        RD                = 1'b0;

  // one bus access and what the ports must show in its ack cycle
  typedef struct packed {
    logic       we;
    reg_index_e adr;
    byte_t      dat;
    byte_t      exp_rdata;
    vram_addr_t exp_addr;
    fine_x_t    exp_fine;
    byte_t      exp_mask;
  } step_t;

  logic       I_clock;
  logic       I_reset;
  wb_req_t    wb_req;
  logic       ack;
  byte_t      rdata;
  vram_addr_t vram_addr;
  fine_x_t    fine_x;
  byte_t      render_mask;

  step_t      steps [$];
  logic       table_ready;
  byte_t      fill_bytes [FILL_BYTES];

  tb_clock #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock
  (
    .I_clock (I_clock),
    .I_reset (I_reset)
  );

  ppu_regs_top uut
  (
    .I_clock     (I_clock),
    .I_reset     (I_reset),
    .wb_req      (wb_req),
    .ack         (ack),
    .rdata       (rdata),
    .vram_addr   (vram_addr),
    .fine_x      (fine_x),
    .render_mask (render_mask)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // failure reporting and compare tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
    if (actual !== expected)
      stop_run($sformatf("error at %0t: %s expected 0x%02h, got 0x%02h",
                         $time, name, expected, actual));
  endtask

  task automatic check_vram_addr(input string name, input vram_addr_t expected,
                                 input vram_addr_t actual);
    if (actual !== expected)
      stop_run($sformatf("error at %0t: %s expected 0x%04h, got 0x%04h",
                         $time, name, expected, actual));
  endtask

  task automatic check_fine(input string name, input fine_x_t expected, input fine_x_t actual);
    if (actual !== expected)
      stop_run($sformatf("error at %0t: %s expected %0d, got %0d",
                         $time, name, expected, actual));
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Wishbone master
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // returns in the ack cycle, after the falling edge, with stb already dropped
  task automatic bus_access(input logic we, input reg_index_e adr, input byte_t dat,
                            output byte_t rd);
    int waited;
    waited = 0;
    @(negedge I_clock);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = dat;
    while (!ack && waited < ACK_LIMIT)
    begin
      @(negedge I_clock);
      waited++;
    end
    if (ack)
    begin
      rd = rdata;
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      wb_req.we  = 1'b0;
    end
    else
      stop_run($sformatf("no ack from the register port within %0d cycles of a %s access",
                         ACK_LIMIT, adr.name()));
  endtask

  task automatic set_vram_address(input vram_addr_t addr);
    byte_t rd;
    bus_access(WR, R_ppu_addr, {2'b00, addr[13:8]}, rd);
    bus_access(WR, R_ppu_addr, addr[7:0], rd);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // access table
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic add_step(input logic we, input reg_index_e adr, input byte_t dat,
                          input byte_t exp_rdata, input vram_addr_t exp_addr,
                          input fine_x_t exp_fine, input byte_t exp_mask);
    step_t s;
    s.we        = we;
    s.adr       = adr;
    s.dat       = dat;
    s.exp_rdata = exp_rdata;
    s.exp_addr  = exp_addr;
    s.exp_fine  = exp_fine;
    s.exp_mask  = exp_mask;
    steps.push_back(s);
  endtask

  // columns are direction, register, data, rdata, vram_addr, fine_x, render_mask
  // data port accesses are writes only, so the read buffer keeps its reset value
  task automatic build_table();
    add_step(WR, R_ppu_mask, 8'h1E, 8'h00, 14'h0000, 3'd0, 8'h1E);
    add_step(WR, R_ppu_addr, 8'hE5, 8'h00, 14'h0000, 3'd0, 8'h1E);  // bits 7:6 dropped
    add_step(WR, R_ppu_addr, 8'h3C, 8'h00, 14'h253C, 3'd0, 8'h1E);
    add_step(WR, R_ppu_scrl, 8'h7D, 8'h00, 14'h253C, 3'd5, 8'h1E);
    add_step(WR, R_ppu_scrl, 8'h5E, 8'h00, 14'h253C, 3'd5, 8'h1E);
    // control write lands in t between the two halves of the address
    add_step(WR, R_ppu_addr, 8'h08, 8'h00, 14'h253C, 3'd5, 8'h1E);
    add_step(WR, R_ppu_ctrl, 8'h03, 8'h00, 14'h253C, 3'd5, 8'h1E);
    add_step(WR, R_ppu_addr, 8'h44, 8'h00, 14'h0C44, 3'd5, 8'h1E);
    // status read in between makes the next address byte a first write again
    add_step(WR, R_ppu_addr, 8'h11, 8'h00, 14'h0C44, 3'd5, 8'h1E);
    add_step(RD, R_ppu_stat, 8'h00, 8'h00, 14'h0C44, 3'd5, 8'h1E);
    add_step(WR, R_ppu_addr, 8'h21, 8'h00, 14'h0C44, 3'd5, 8'h1E);
    add_step(WR, R_ppu_addr, 8'h80, 8'h00, 14'h2180, 3'd5, 8'h1E);
    add_step(WR, R_ppu_data, 8'hA1, 8'h00, 14'h2181, 3'd5, 8'h1E);
    add_step(WR, R_ppu_data, 8'hA2, 8'h00, 14'h2182, 3'd5, 8'h1E);
    add_step(WR, R_ppu_ctrl, 8'h04, 8'h00, 14'h2182, 3'd5, 8'h1E);  // step of 32
    add_step(WR, R_ppu_data, 8'hA3, 8'h00, 14'h21A2, 3'd5, 8'h1E);
    add_step(WR, R_ppu_data, 8'hA4, 8'h00, 14'h21C2, 3'd5, 8'h1E);
    add_step(WR, R_ppu_addr, 8'h3F, 8'h00, 14'h21C2, 3'd5, 8'h1E);
    add_step(WR, R_ppu_addr, 8'hF0, 8'h00, 14'h3FF0, 3'd5, 8'h1E);
    add_step(WR, R_ppu_data, 8'hA5, 8'h00, 14'h0010, 3'd5, 8'h1E);  // wraps past 16 KiB
    add_step(WR, R_ppu_ctrl, 8'h00, 8'h00, 14'h0010, 3'd5, 8'h1E);
    add_step(WR, R_ppu_addr, 8'h3F, 8'h00, 14'h0010, 3'd5, 8'h1E);
    add_step(WR, R_ppu_addr, 8'hFF, 8'h00, 14'h3FFF, 3'd5, 8'h1E);
    add_step(WR, R_ppu_data, 8'hA6, 8'h00, 14'h0000, 3'd5, 8'h1E);
    add_step(RD, R_ppu_mask, 8'h00, 8'h00, 14'h0000, 3'd5, 8'h1E);  // mask reads back zero
  endtask

  task automatic apply_table();
    step_t s;
    byte_t rd;
    int    i;
    for (i = 0; i < steps.size(); i++)
    begin
      s = steps[i];
      bus_access(s.we, s.adr, s.dat, rd);
      check_byte($sformatf("rdata (step %0d)", i), s.exp_rdata, rd);
      check_vram_addr($sformatf("vram_addr (step %0d)", i), s.exp_addr, vram_addr);
      check_fine($sformatf("fine_x (step %0d)", i), s.exp_fine, fine_x);
      check_byte($sformatf("render_mask (step %0d)", i), s.exp_mask, render_mask);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // video memory fill and read back
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic fill_and_read_back();
    logic [31:0] lcg_state;
    byte_t       rd;
    int          k;
    lcg_state = LCG_SEED;
    for (k = 0; k < FILL_BYTES; k++)
    begin
      lcg_state     = lcg_next(lcg_state);
      fill_bytes[k] = lcg_state[23:16];
    end

    set_vram_address(FILL_BASE);
    check_vram_addr("vram_addr", FILL_BASE, vram_addr);
    for (k = 0; k < FILL_BYTES; k++)
    begin
      bus_access(WR, R_ppu_data, fill_bytes[k], rd);
      check_vram_addr("vram_addr", vram_addr_t'(FILL_BASE + k + 1), vram_addr);
    end

    set_vram_address(FILL_BASE);
    bus_access(RD, R_ppu_data, 8'h00, rd);
    check_byte("rdata (stale buffer)", 8'h00, rd);  // nothing was fetched since reset
    for (k = 0; k < FILL_BYTES; k++)
    begin
      bus_access(RD, R_ppu_data, 8'h00, rd);
      check_byte($sformatf("rdata (fill byte %0d)", k), fill_bytes[k], rd);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence and watchdog
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial
  begin
    wb_req      = '0;
    table_ready = 1'b0;
    build_table();
    table_ready = 1'b1;

    wait (I_reset === 1'b1);
    @(negedge I_clock);
    check_vram_addr("vram_addr after reset", '0, vram_addr);
    check_fine("fine_x after reset", '0, fine_x);
    check_byte("render_mask after reset", '0, render_mask);

    apply_table();
    fill_and_read_back();

    $display("PASS: all tests");
    $finish;
  end

  initial
  begin
    int unsigned limit_ns;
    wait (table_ready === 1'b1);
    limit_ns = (steps.size() + FILL_LEN) * CYCLES_PER_ACCESS * CLK_PERIOD_NS
               + RESET_CYCLES * CLK_PERIOD_NS;
    #(limit_ns * 1ns);
    stop_run($sformatf("timeout, the tests did not finish within %0d ns", limit_ns));
  end

endmodule
